//--- vrf_pkg.sv
`default_nettype none

package vrf_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Vector register length and memory word width
  localparam int unsigned VLEN       = 128;
  localparam int unsigned PIPE_WIDTH = 32;

  // Words that make up one vector register
  localparam int unsigned NUM_MEM_OPS = VLEN / PIPE_WIDTH;

  // Signed LMUL code, -2 (quarter) up to 3 (eight registers)
  localparam int unsigned LMUL_WIDTH = 3;

  // Iteration count, up to NUM_MEM_OPS << 3
  localparam int unsigned ITER_WIDTH = 6;
  localparam logic [ITER_WIDTH-1:0] ITER_BASE = ITER_WIDTH'(NUM_MEM_OPS);

  //////////////////////////////
  // Operation select
  //////////////////////////////

  localparam int unsigned SEL_WIDTH = 3;
  localparam int unsigned SEL_RS1   = 0;
  localparam int unsigned SEL_RS2   = 1;
  localparam int unsigned SEL_RD    = 2;

  //////////////////////////////
  // Sequencer states
  //////////////////////////////

  localparam int unsigned STATE_WIDTH = 3;
  localparam logic [STATE_WIDTH-1:0] ST_IDLE  = 3'd0;
  localparam logic [STATE_WIDTH-1:0] ST_START = 3'd1;
  localparam logic [STATE_WIDTH-1:0] ST_READ1 = 3'd2;
  localparam logic [STATE_WIDTH-1:0] ST_READ2 = 3'd3;
  localparam logic [STATE_WIDTH-1:0] ST_WRITE = 3'd4;
  localparam logic [STATE_WIDTH-1:0] ST_NEXT  = 3'd5;

endpackage

`default_nettype wire

//--- vrf_iter_counter.sv
`timescale 1ns/10ps
`default_nettype none

module vrf_iter_counter (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic signed [vrf_pkg::LMUL_WIDTH-1:0] lmul_i,
  input  logic                                  iter_load_i,
  input  logic                                  iter_step_i,
  output logic                                  last_iter_o
);

  logic [vrf_pkg::ITER_WIDTH-1:0] count_q;
  logic [vrf_pkg::ITER_WIDTH-1:0] count_d;
  logic [vrf_pkg::ITER_WIDTH-1:0] load_val;
  logic [vrf_pkg::LMUL_WIDTH-1:0] lmul_mag;
  logic                           lmul_neg;

  //////////////////////////////
  // LMUL decode
  //////////////////////////////

  // Sign and magnitude of the multiplier code
  assign lmul_neg = lmul_i[vrf_pkg::LMUL_WIDTH-1];
  assign lmul_mag = lmul_neg ? -lmul_i : lmul_i;

  // Fractional LMUL shrinks the word count, integer LMUL grows it
  always_comb begin
    if (lmul_neg) begin
      load_val = vrf_pkg::ITER_BASE >> lmul_mag;
    end else begin
      load_val = vrf_pkg::ITER_BASE << lmul_mag;
    end
  end

  //////////////////////////////
  // Down counter
  //////////////////////////////

  always_comb begin
    count_d = count_q;
    if (iter_load_i) begin
      count_d = load_val;
    end else if (iter_step_i) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  // One iteration left
  assign last_iter_o = (count_q == {{(vrf_pkg::ITER_WIDTH-1){1'b0}}, 1'b1});

endmodule

`default_nettype wire

//--- vrf_access_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module vrf_access_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Instruction side
  input  logic                          req_i,
  input  logic [vrf_pkg::SEL_WIDTH-1:0] sel_operation_i,
  output logic                          vector_done_o,

  // Memory handshake
  input  logic                          data_gnt_i,
  output logic                          data_req_o,
  output logic                          data_we_o,

  // Address generator strobes
  output logic                          agu_load_o,
  output logic                          agu_get_rs1_o,
  output logic                          agu_get_rs2_o,
  output logic                          agu_get_rd_o,
  output logic                          agu_incr_o,

  // Iteration counter
  input  logic                          last_iter_i,
  output logic                          iter_load_o,
  output logic                          iter_step_o
);

  logic [vrf_pkg::STATE_WIDTH-1:0] state_q;
  logic [vrf_pkg::STATE_WIDTH-1:0] state_d;
  logic [vrf_pkg::STATE_WIDTH-1:0] first_st;
  logic [vrf_pkg::STATE_WIDTH-1:0] acc_st;
  logic [vrf_pkg::STATE_WIDTH-1:0] after_st;
  logic                            sel_rs1;
  logic                            sel_rs2;
  logic                            sel_rd;
  logic                            sel_any;
  logic                            accept;
  logic                            acc_active;
  logic                            acc_done;

  assign sel_rs1 = sel_operation_i[vrf_pkg::SEL_RS1];
  assign sel_rs2 = sel_operation_i[vrf_pkg::SEL_RS2];
  assign sel_rd  = sel_operation_i[vrf_pkg::SEL_RD];
  assign sel_any = |sel_operation_i;

  //////////////////////////////
  // Access selection
  //////////////////////////////

  // First enabled access of every iteration
  always_comb begin
    if (sel_rs1) begin
      first_st = vrf_pkg::ST_READ1;
    end else if (sel_rs2) begin
      first_st = vrf_pkg::ST_READ2;
    end else begin
      first_st = vrf_pkg::ST_WRITE;
    end
  end

  // Access requested this cycle, ST_IDLE when none
  // START and NEXT issue the first access themselves to avoid a bubble
  always_comb begin
    acc_st = vrf_pkg::ST_IDLE;
    case (state_q)
      vrf_pkg::ST_START: begin
        if (sel_any) begin
          acc_st = first_st;
        end
      end
      vrf_pkg::ST_NEXT: begin
        if (!last_iter_i) begin
          acc_st = first_st;
        end
      end
      vrf_pkg::ST_READ1, vrf_pkg::ST_READ2, vrf_pkg::ST_WRITE: begin
        acc_st = state_q;
      end
      default: begin
        acc_st = vrf_pkg::ST_IDLE;
      end
    endcase
  end

  // Where to go once the current access is granted
  always_comb begin
    case (acc_st)
      vrf_pkg::ST_READ1: begin
        if (sel_rs2) begin
          after_st = vrf_pkg::ST_READ2;
        end else if (sel_rd) begin
          after_st = vrf_pkg::ST_WRITE;
        end else begin
          after_st = vrf_pkg::ST_NEXT;
        end
      end
      vrf_pkg::ST_READ2: begin
        after_st = sel_rd ? vrf_pkg::ST_WRITE : vrf_pkg::ST_NEXT;
      end
      default: begin
        after_st = vrf_pkg::ST_NEXT;
      end
    endcase
  end

  //////////////////////////////
  // State register
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      vrf_pkg::ST_IDLE: begin
        if (req_i) begin
          state_d = vrf_pkg::ST_START;
        end
      end
      // Nothing selected, drop the instruction
      vrf_pkg::ST_START: begin
        if (!sel_any) begin
          state_d = vrf_pkg::ST_IDLE;
        end else if (data_gnt_i) begin
          state_d = after_st;
        end
      end
      vrf_pkg::ST_READ1, vrf_pkg::ST_READ2, vrf_pkg::ST_WRITE: begin
        if (data_gnt_i) begin
          state_d = after_st;
        end
      end
      vrf_pkg::ST_NEXT: begin
        if (last_iter_i) begin
          state_d = vrf_pkg::ST_IDLE;
        end else if (data_gnt_i) begin
          state_d = after_st;
        end
      end
      default: begin
        state_d = vrf_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= vrf_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign accept     = (state_q == vrf_pkg::ST_IDLE) && req_i;
  assign acc_active = (acc_st != vrf_pkg::ST_IDLE);
  assign acc_done   = acc_active && data_gnt_i;

  assign data_req_o    = acc_active;
  assign data_we_o     = (acc_st == vrf_pkg::ST_WRITE);
  assign agu_load_o    = accept;
  assign agu_get_rs1_o = (acc_st == vrf_pkg::ST_READ1);
  assign agu_get_rs2_o = (acc_st == vrf_pkg::ST_READ2);
  assign agu_get_rd_o  = (acc_st == vrf_pkg::ST_WRITE);
  assign agu_incr_o    = acc_done;

  // Count steps once the next iteration actually starts
  assign iter_load_o   = accept;
  assign iter_step_o   = acc_done && (state_q == vrf_pkg::ST_NEXT);
  assign vector_done_o = (state_q == vrf_pkg::ST_NEXT) && last_iter_i;

endmodule

`default_nettype wire

//--- vrf_operand_regs.sv
`timescale 1ns/10ps
`default_nettype none

module vrf_operand_regs (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  // Observed request side
  input  logic                           data_req_i,
  input  logic                           data_we_i,
  input  logic                           data_gnt_i,
  input  logic                           agu_get_rs1_i,

  // Read response
  input  logic                           data_rvalid_i,
  input  logic [vrf_pkg::PIPE_WIDTH-1:0] data_rdata_i,

  // Captured operands
  output logic [vrf_pkg::PIPE_WIDTH-1:0] rdata_a_o,
  output logic [vrf_pkg::PIPE_WIDTH-1:0] rdata_b_o
);

  logic                           read_gnt;
  logic                           tag_rs1_q;
  logic [vrf_pkg::PIPE_WIDTH-1:0] rs1_q;
  logic [vrf_pkg::PIPE_WIDTH-1:0] rs2_q;

  // Read accepted by the memory this cycle
  assign read_gnt = data_req_i && data_gnt_i && !data_we_i;

  //////////////////////////////
  // Response tagging
  //////////////////////////////

  // High when the outstanding read belongs to rs1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_rs1_q <= 1'b0;
    end else if (read_gnt) begin
      tag_rs1_q <= agu_get_rs1_i;
    end
  end

  // Returned word lands in the tagged operand
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rs1_q <= '0;
      rs2_q <= '0;
    end else if (data_rvalid_i) begin
      if (tag_rs1_q) begin
        rs1_q <= data_rdata_i;
      end else begin
        rs2_q <= data_rdata_i;
      end
    end
  end

  assign rdata_a_o = rs1_q;
  assign rdata_b_o = rs2_q;

endmodule

`default_nettype wire

//--- vrf_interface.sv
`timescale 1ns/10ps
`default_nettype none

module vrf_interface (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Instruction side
  input  logic                                  req_i,
  input  logic [vrf_pkg::SEL_WIDTH-1:0]         sel_operation_i,
  input  logic signed [vrf_pkg::LMUL_WIDTH-1:0] lmul_i,
  input  logic [vrf_pkg::PIPE_WIDTH-1:0]        wdata_i,
  output logic [vrf_pkg::PIPE_WIDTH-1:0]        rdata_a_o,
  output logic [vrf_pkg::PIPE_WIDTH-1:0]        rdata_b_o,
  output logic                                  vector_done_o,

  // Register memory port
  output logic                                  data_req_o,
  input  logic                                  data_gnt_i,
  input  logic                                  data_rvalid_i,
  output logic                                  data_we_o,
  output logic [vrf_pkg::PIPE_WIDTH-1:0]        data_wdata_o,
  input  logic [vrf_pkg::PIPE_WIDTH-1:0]        data_rdata_i,

  // Address generator
  output logic                                  agu_load_o,
  output logic                                  agu_get_rs1_o,
  output logic                                  agu_get_rs2_o,
  output logic                                  agu_get_rd_o,
  output logic                                  agu_incr_o
);

  logic iter_load;
  logic iter_step;
  logic last_iter;

  //////////////////////////////
  // Iteration count
  //////////////////////////////

  vrf_iter_counter vrf_iter_counter_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lmul_i      (lmul_i),
    .iter_load_i (iter_load),
    .iter_step_i (iter_step),
    .last_iter_o (last_iter)
  );

  //////////////////////////////
  // Access sequencer
  //////////////////////////////

  vrf_access_fsm vrf_access_fsm_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .sel_operation_i (sel_operation_i),
    .vector_done_o   (vector_done_o),
    .data_gnt_i      (data_gnt_i),
    .data_req_o      (data_req_o),
    .data_we_o       (data_we_o),
    .agu_load_o      (agu_load_o),
    .agu_get_rs1_o   (agu_get_rs1_o),
    .agu_get_rs2_o   (agu_get_rs2_o),
    .agu_get_rd_o    (agu_get_rd_o),
    .agu_incr_o      (agu_incr_o),
    .last_iter_i     (last_iter),
    .iter_load_o     (iter_load),
    .iter_step_o     (iter_step)
  );

  //////////////////////////////
  // Operand capture
  //////////////////////////////

  vrf_operand_regs vrf_operand_regs_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_o),
    .data_we_i     (data_we_o),
    .data_gnt_i    (data_gnt_i),
    .agu_get_rs1_i (agu_get_rs1_o),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rdata_a_o     (rdata_a_o),
    .rdata_b_o     (rdata_b_o)
  );

  // Result word goes straight to memory
  assign data_wdata_o = wdata_i;

endmodule

`default_nettype wire

//--- vrf_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module vrf_mem_model (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        data_req_i,
  input  logic        data_we_i,
  input  logic        agu_load_i,
  input  logic        agu_get_rs1_i,
  input  logic        agu_get_rs2_i,
  input  logic [31:0] data_wdata_i,
  input  logic [31:0] read_base_i,
  output logic        data_gnt_o,
  output logic        data_rvalid_o,
  output logic [31:0] data_rdata_o,
  output logic [31:0] rs1_cnt_o,
  output logic [31:0] rs2_cnt_o,
  output logic [31:0] rd_cnt_o
);

  logic [1:0]  stall_q;
  logic [31:0] read_idx_q;
  logic [31:0] wr_log [64];
  logic        read_gnt;
  logic        write_gnt;

  assign data_gnt_o = data_req_i && (stall_q == 2'd0);
  assign read_gnt   = data_gnt_o && !data_we_i;
  assign write_gnt  = data_gnt_o && data_we_i;

  // Stall cycles ahead of the next grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_q <= 2'd0;
    end else if (data_gnt_o) begin
      stall_q <= 2'($urandom % 4);
    end else if (data_req_i && (stall_q != 2'd0)) begin
      stall_q <= stall_q - 2'd1;
    end
  end

  // Read data is the base plus the running read index
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_rvalid_o <= 1'b0;
      data_rdata_o  <= '0;
      read_idx_q    <= '0;
      rs1_cnt_o     <= '0;
      rs2_cnt_o     <= '0;
      rd_cnt_o      <= '0;
    end else begin
      data_rvalid_o <= read_gnt;
      if (agu_load_i) begin
        read_idx_q <= '0;
        rs1_cnt_o  <= '0;
        rs2_cnt_o  <= '0;
        rd_cnt_o   <= '0;
      end
      if (read_gnt) begin
        data_rdata_o <= read_base_i + read_idx_q;
        read_idx_q   <= read_idx_q + 32'd1;
      end
      if (read_gnt && agu_get_rs1_i) begin
        rs1_cnt_o <= rs1_cnt_o + 32'd1;
      end
      if (read_gnt && agu_get_rs2_i) begin
        rs2_cnt_o <= rs2_cnt_o + 32'd1;
      end
      if (write_gnt) begin
        rd_cnt_o <= rd_cnt_o + 32'd1;
      end
    end
  end

  // Write words in grant order
  always_ff @(posedge clk_i) begin
    if (write_gnt) begin
      wr_log[rd_cnt_o[5:0]] <= data_wdata_i;
    end
  end

endmodule

`default_nettype wire

//--- vrf_interface_tb.sv
`timescale 1ns/10ps
`default_nettype none

module vrf_interface_tb;

  localparam int unsigned COLS       = 5;
  localparam int unsigned WAIT_LIMIT = 2000;
  localparam int unsigned IDLE_WAIT  = 24;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  req;
  logic [vrf_pkg::SEL_WIDTH-1:0]         sel_operation;
  logic signed [vrf_pkg::LMUL_WIDTH-1:0] lmul;
  logic [31:0]                           wdata;
  logic [31:0]                           rdata_a;
  logic [31:0]                           rdata_b;
  logic                                  vector_done;
  logic                                  data_req;
  logic                                  data_gnt;
  logic                                  data_rvalid;
  logic                                  data_we;
  logic [31:0]                           data_wdata;
  logic [31:0]                           data_rdata;
  logic                                  agu_load;
  logic                                  agu_get_rs1;
  logic                                  agu_get_rs2;
  logic                                  agu_get_rd;
  logic                                  agu_incr;
  logic [31:0]                           read_base;
  logic [31:0]                           rs1_cnt;
  logic [31:0]                           rs2_cnt;
  logic [31:0]                           rd_cnt;

  logic [31:0] stim_mem [256];
  logic [31:0] wr_base;
  logic [31:0] wr_idx;
  logic [31:0] exp_a;
  logic [31:0] exp_b;
  logic [1:0]  exp_kind;
  logic [1:0]  got_kind;
  bit          timed_out;
  int unsigned err_cnt    = 0;
  int unsigned load_total = 0;
  int unsigned done_total = 0;
  int unsigned pass_cnt   = 0;
  int unsigned fail_cnt   = 0;

  vrf_interface vrf_interface_inst (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .req_i           (req),
    .sel_operation_i (sel_operation),
    .lmul_i          (lmul),
    .wdata_i         (wdata),
    .rdata_a_o       (rdata_a),
    .rdata_b_o       (rdata_b),
    .vector_done_o   (vector_done),
    .data_req_o      (data_req),
    .data_gnt_i      (data_gnt),
    .data_rvalid_i   (data_rvalid),
    .data_we_o       (data_we),
    .data_wdata_o    (data_wdata),
    .data_rdata_i    (data_rdata),
    .agu_load_o      (agu_load),
    .agu_get_rs1_o   (agu_get_rs1),
    .agu_get_rs2_o   (agu_get_rs2),
    .agu_get_rd_o    (agu_get_rd),
    .agu_incr_o      (agu_incr)
  );

  vrf_mem_model mem_model_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .data_req_i    (data_req),
    .data_we_i     (data_we),
    .agu_load_i    (agu_load),
    .agu_get_rs1_i (agu_get_rs1),
    .agu_get_rs2_i (agu_get_rs2),
    .data_wdata_i  (data_wdata),
    .read_base_i   (read_base),
    .data_gnt_o    (data_gnt),
    .data_rvalid_o (data_rvalid),
    .data_rdata_o  (data_rdata),
    .rs1_cnt_o     (rs1_cnt),
    .rs2_cnt_o     (rs2_cnt),
    .rd_cnt_o      (rd_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Next enabled access after the given one with rd wrapping to rs1
  function automatic logic [1:0] next_access(input logic [2:0] sel, input logic [1:0] from);
    logic [1:0] pos;
    logic [1:0] found;
    found = from;
    for (int k = 3; k >= 1; k--) begin
      pos = 2'((32'(from) + k) % 3);
      if (sel[pos]) begin
        found = pos;
      end
    end
    return found;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string label, input int unsigned err_start);
    if (err_cnt == err_start && !timed_out) begin
      pass_cnt++;
      $display("Test %s: ok", label);
    end else begin
      fail_cnt++;
      $display("Test %s: failed", label);
    end
  endtask

  // Follows the write grants so wdata always holds the next word
  task automatic wait_done(input int unsigned idx);
    int unsigned cyc;
    bit          done;
    cyc  = 0;
    done = 1'b0;
    while (!done && cyc < WAIT_LIMIT) begin
      @(posedge clk);
      if (cyc == 0) begin
        check_value("data_req_o", 32'(data_req), 32'd1);
      end
      if (data_req && data_gnt && data_we) begin
        wr_idx = wr_idx + 32'd1;
        wdata <= wr_base + wr_idx;
      end
      done = vector_done;
      cyc++;
    end
    if (!done) begin
      $display("Timeout, no vector_done_o within %0d cycles in test %0d", WAIT_LIMIT, idx);
      timed_out = 1'b1;
      err_cnt++;
    end
  endtask

  task automatic watch_empty(input int unsigned idx);
    for (int unsigned cyc = 0; cyc < IDLE_WAIT; cyc++) begin
      @(posedge clk);
      assert (!data_req && !vector_done) else begin
        $display("Empty select in test %0d issued an access or a done pulse", idx);
        err_cnt++;
      end
    end
  endtask

  task automatic run_test(input int unsigned idx);
    logic [31:0] code;
    logic [31:0] sel_w;
    logic [31:0] rbase;
    logic [31:0] iters;
    logic [31:0] n_reads;
    int unsigned base;
    int unsigned err_start;
    int unsigned load_start;
    int unsigned done_start;
    base       = 1 + idx * COLS;
    code       = stim_mem[base];
    sel_w      = stim_mem[base + 1];
    rbase      = stim_mem[base + 2];
    wr_base    = stim_mem[base + 3];
    iters      = stim_mem[base + 4];
    err_start  = err_cnt;
    load_start = load_total;
    done_start = done_total;
    @(posedge clk);
    lmul          <= code[2:0];
    sel_operation <= sel_w[2:0];
    read_base     <= rbase;
    wdata         <= wr_base;
    wr_idx        = '0;
    req           <= 1'b1;
    @(posedge clk);
    req <= 1'b0;
    if (sel_w[2:0] == 3'b000) begin
      watch_empty(idx);
      iters = '0;
    end else begin
      wait_done(idx);
    end
    if (!timed_out) begin
      // Cycle after the done pulse
      @(posedge clk);
      check_value("agu_load_o pulses", load_total - load_start, 32'd1);
      check_value("vector_done_o pulses", done_total - done_start,
                  (sel_w[2:0] != 3'b000) ? 32'd1 : 32'd0);
      check_value("rs1 grants", rs1_cnt, sel_w[0] ? iters : 32'd0);
      check_value("rs2 grants", rs2_cnt, sel_w[1] ? iters : 32'd0);
      check_value("rd grants", rd_cnt, sel_w[2] ? iters : 32'd0);
      n_reads = (32'(sel_w[0]) + 32'(sel_w[1])) * iters;
      if (sel_w[0]) begin
        exp_a = rbase + n_reads - (sel_w[1] ? 32'd2 : 32'd1);
      end
      if (sel_w[1]) begin
        exp_b = rbase + n_reads - 32'd1;
      end
      check_value("rdata_a_o", rdata_a, exp_a);
      check_value("rdata_b_o", rdata_b, exp_b);
      for (int i = 0; i < 64; i++) begin
        if (32'(i) < rd_cnt) begin
          check_value("data_wdata_o", mem_model_inst.wr_log[i], wr_base + 32'(i));
        end
      end
    end
    report_test($sformatf("%0d lmul %0d sel %03b iterations %0d", idx,
                          $signed(code[2:0]), sel_w[2:0], iters), err_start);
  endtask

  //////////////////////////////
  // Protocol monitor
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      assert (agu_incr === (data_req && data_gnt)) else begin
        $display("[FAIL] agu_incr_o got 0x%0h expected 0x%0h", agu_incr, data_req && data_gnt);
        err_cnt++;
      end
      assert (!data_we || agu_get_rd) else begin
        $display("data_we_o was high without agu_get_rd_o");
        err_cnt++;
      end
      if (agu_load) begin
        load_total <= load_total + 1;
        exp_kind = next_access(sel_operation, 2'd2);
      end
      if (vector_done) begin
        done_total <= done_total + 1;
      end
      // Kinds follow the select bit positions
      if (data_req && data_gnt) begin
        got_kind = agu_get_rs1 ? 2'd0 : (agu_get_rs2 ? 2'd1 : 2'd2);
        assert ($onehot({agu_get_rs1, agu_get_rs2, agu_get_rd}) && got_kind == exp_kind)
        else begin
          $display("[FAIL] agu_get strobe kind got 0x%0h expected 0x%0h", got_kind, exp_kind);
          err_cnt++;
        end
        exp_kind = next_access(sel_operation, got_kind);
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int unsigned num_tests;
    int unsigned err_start;
    void'($urandom(32'haace_6203));
    rst_n         = 1'b0;
    req           = 1'b0;
    sel_operation = '0;
    lmul          = '0;
    wdata         = '0;
    read_base     = '0;
    wr_base       = '0;
    wr_idx        = '0;
    exp_a         = '0;
    exp_b         = '0;
    exp_kind      = '0;
    timed_out     = 1'b0;
    $readmemh("vrf_stimulus.txt", stim_mem);
    num_tests = stim_mem[0];
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // Idle outputs before any request
    err_start = err_cnt;
    @(posedge clk);
    check_value("{data_req_o,data_we_o,vector_done_o}", 32'({data_req, data_we, vector_done}), 0);
    check_value("{agu_load_o,agu_get_rs1_o,agu_get_rs2_o,agu_get_rd_o,agu_incr_o}",
                32'({agu_load, agu_get_rs1, agu_get_rs2, agu_get_rd, agu_incr}), 0);
    check_value("rdata_a_o", rdata_a, 32'd0);
    check_value("rdata_b_o", rdata_b, 32'd0);
    report_test("reset", err_start);
    for (int unsigned t = 0; t < num_tests && !timed_out; t++) begin
      run_test(t);
    end
    $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vrf_stimulus.txt
// Columns: lmul code, select (bit 0 rs1, bit 1 rs2, bit 2 rd), read base, write base,
// expected iteration count; all hex, the word below is the number of tests
15
0 1 10000000 a0000000 04
0 2 11000010 a1000100 04
0 4 12000020 a2000200 04
0 3 13000030 a3000300 04
0 5 14000040 a4000400 04
0 6 15000050 a5000500 04
0 7 16000060 a6000600 04
6 7 17000070 a7000700 01
7 7 18000080 a8000800 02
1 7 19000090 a9000900 08
2 7 1a0000a0 aa000a00 10
3 7 1b0000b0 ab000b00 20
0 0 1c0000c0 ac000c00 04
1 3 1d0000d0 ad000d00 08
6 1 1e0000e0 ae000e00 01
7 4 1f0000f0 af000f00 02
3 5 20000100 b0001000 20
2 6 21000110 b1001100 10
0 0 22000120 b2001200 04
6 5 23000130 b3001300 01
3 2 24000140 b4001400 20

//--- flist.f
vrf_pkg.sv
vrf_iter_counter.sv
vrf_access_fsm.sv
vrf_operand_regs.sv
vrf_interface.sv
vrf_mem_model.sv
vrf_interface_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vrf_interface testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  -f flist.f --top-module vrf_interface_tb \
  --Mdir "$BUILD_DIR" -o vrf_sim

"./$BUILD_DIR/vrf_sim" | tee "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi
echo "Simulation finished without failures"
